/* list.f */
src/ocpPkg.sv
src/respFifo.sv
src/ocpRequestFsm.sv
src/ocpRespCapture.sv
src/respStreamOut.sv
src/ocpMaster.sv
tb/ocpSlaveModel.sv
tb/tbOcpMaster.sv

/* Bender.yml */
package:
  name: ocp_master

sources:
  # Package first, then leaf blocks, then the top level
  - src/ocpPkg.sv
  - src/respFifo.sv
  - src/ocpRequestFsm.sv
  - src/ocpRespCapture.sv
  - src/respStreamOut.sv
  - src/ocpMaster.sv
  - target: test
    files:
      - tb/ocpSlaveModel.sv
      - tb/tbOcpMaster.sv

/* tb/tbOcpMaster.sv */
/*
  Testbench for the OCP master. Inputs change on the falling clock edge and
  OCP and stream beats are checked at the rising edge that completes them.
  Stimulus comes from a table. Expected addresses, data and tkeep follow
  the INCR/STRM and address-region rules of the slave model.
  A cycle limit bounds the run.
*/
`timescale 1ns/1ps

module tbOcpMaster;
  import ocpPkg::*;

  typedef struct packed {
    logic       isRead;
    addrT       addr;
    burstLenT   len;
    burstSeqT   seq;
    byteEnT     be;
    dataT       wdBase;
    logic [7:0] duty;
    burstLenT   expBeats;
    logic       expErr;
  } stimT;

  localparam int NumTests = 10;

  logic Clk;
  logic reset;
  logic readRequest, writeRequest, busy, writeDataAccept;
  addrT address, MAddr;
  burstLenT burstLength, MBurstLength;
  burstSeqT burstSeq, MBurstSeq;
  byteEnT byteEnables, MByteEn, streamKeep;
  dataT writeData, MData, SData, streamData;
  ocpCmdT MCmd;
  ocpRespT SResp;
  logic MReqLast, SCmdAccept, SRespLast, MRespAccept;
  logic streamValid, streamReady, streamLast, respError;
  int acceptedBeats, respDone;

  stimT stimTable [NumTests];
  // Current burst as seen by the monitors
  logic       curRead;
  addrT       curBase;
  burstLenT   curLen;
  burstSeqT   curSeq;
  byteEnT     curBe;
  dataT       curWd;
  logic [7:0] curDuty;
  int         reqBeat, wrBeat, streamBeats, cycleCount, timeoutLimit;
  logic       sawStall;
  // Stream beats still due
  dataT       expData [$];
  byteEnT     expKeep [$];
  logic       expLast [$];

  ocpMaster i_ocpMaster (.*);

  ocpSlaveModel i_ocpSlaveModel (
    .Clk (Clk), .reset (reset), .MCmd (MCmd), .MAddr (MAddr),
    .MBurstLength (MBurstLength), .SCmdAccept (SCmdAccept), .SResp (SResp),
    .SData (SData), .SRespLast (SRespLast), .MRespAccept (MRespAccept),
    .acceptCount (acceptedBeats), .respCount (respDone)
  );

  initial begin
    Clk = 1'b0;
    forever #5 Clk = ~Clk;
  end

  task automatic abortRun(input string line);
    $display("%s", line);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic checkCmd(input ocpCmdT cmd, input addrT addr, input dataT data,
                          input byteEnT be, input logic last, input burstLenT len,
                          input burstSeqT seq, input ocpCmdT expCmd, input addrT expAddr,
                          input dataT expDat, input byteEnT expBe, input logic expLst,
                          input burstLenT expLen, input burstSeqT expSeq);
    // MData only means something on writes
    if (cmd !== expCmd || addr !== expAddr || be !== expBe || last !== expLst ||
        len !== expLen || seq !== expSeq || (expCmd == CmdWr && data !== expDat))
      abortRun($sformatf(
        "FAIL t=%0t: OCP beat %0d %h %h %h %b %0d %0d, expected %0d %h %h %h %b %0d %0d",
        $time, cmd, addr, data, be, last, len, seq,
        expCmd, expAddr, expDat, expBe, expLst, expLen, expSeq));
  endtask

  task automatic checkBeat(input dataT data, input byteEnT keep, input logic last,
                           input dataT expDat, input byteEnT expKp, input logic expLst);
    if (data !== expDat || keep !== expKp || last !== expLst)
      abortRun($sformatf("FAIL t=%0t: stream beat %h %h %b, expected %h %h %b",
        $time, data, keep, last, expDat, expKp, expLst));
  endtask

  task automatic checkFlag(input logic actual, input logic expected, input string what);
    if (actual !== expected)
      abortRun($sformatf("FAIL t=%0t: %s is %b, expected %b", $time, what, actual, expected));
  endtask

  // Next falling edge and the bridge data and tready for that cycle
  task automatic stepCycle();
    @(negedge Clk);
    writeData   = curWd + dataT'(wrBeat);
    streamReady = (($urandom % 100) < curDuty);
  endtask

  task automatic queueExpected(input addrT base, input burstLenT len, input burstSeqT seq);
    addrT a;
    for (int i = 0; i < len; i++) begin
      a = (seq == SeqIncr) ? base + addrT'(i * 4) : base;
      // ERR region leaves no stream beat
      if (a[31:28] != 4'hE) begin
        expData.push_back(a ^ 32'h5A5A0000);
        expKeep.push_back((a[31:28] == 4'hF) ? 4'h0 : 4'hF);
        expLast.push_back(i == len - 1);
      end
    end
  endtask

  // Request beats checked on the accepting edge
  always @(posedge Clk) begin : reqMonitor
    addrT expAddr;
    if (!reset) begin
      // Write data handshake pulses on accepted write beats only
      checkFlag(writeDataAccept, !curRead && (MCmd != CmdIdle) && SCmdAccept,
                "writeDataAccept");
      if (writeDataAccept)
        wrBeat++;
    end
    if (!reset && (MCmd != CmdIdle) && SCmdAccept) begin
      if (reqBeat >= curLen)
        abortRun("OCP request carried more beats than the burst length");
      expAddr = (curSeq == SeqIncr) ? curBase + addrT'(reqBeat * 4) : curBase;
      checkCmd(MCmd, MAddr, MData, MByteEn, MReqLast, MBurstLength, MBurstSeq,
               curRead ? CmdRd : CmdWr, expAddr, curWd + dataT'(reqBeat), curBe,
               reqBeat == curLen - 1, curLen, curSeq);
      reqBeat++;
    end
  end

  always @(posedge Clk) begin
    if (!reset) begin
      if (!MRespAccept)
        sawStall = 1'b1;
      if (streamValid && streamReady) begin
        if (expData.size() == 0)
          abortRun($sformatf("Stream beat %h appeared with no read data due", streamData));
        checkBeat(streamData, streamKeep, streamLast,
                  expData.pop_front(), expKeep.pop_front(), expLast.pop_front());
        streamBeats++;
      end
    end
  end

  // Hang guard
  always @(posedge Clk) begin
    cycleCount++;
    if (timeoutLimit > 0 && cycleCount > timeoutLimit)
      abortRun($sformatf("Timeout, run still going after %0d cycles", timeoutLimit));
  end

  initial begin : mainSeq
    stimT s;
    int   rdIssued;
    int   totalBeats;
    void'($urandom(32'h6a7d4446));
    //               read addr          len seq      be    wdBase        duty beats err
    stimTable[0] = '{0, 32'h10000000, 4, SeqIncr, 4'hF, 32'h11110000, 100, 0, 0};
    stimTable[1] = '{0, 32'h20000040, 3, SeqStrm, 4'h3, 32'h22220000, 100, 0, 0};
    stimTable[2] = '{0, 32'h30000010, 1, SeqIncr, 4'hC, 32'hABCD0000, 80, 0, 0};
    stimTable[3] = '{1, 32'h10000100, 4, SeqIncr, 4'hF, 32'h0, 100, 4, 0};
    stimTable[4] = '{1, 32'h20000200, 3, SeqStrm, 4'hF, 32'h0, 70, 3, 0};
    stimTable[5] = '{1, 32'hF0000020, 2, SeqIncr, 4'hF, 32'h0, 100, 2, 0};
    stimTable[6] = '{1, 32'hE0000000, 2, SeqIncr, 4'hF, 32'h0, 100, 0, 1};
    // Slow tready fills the FIFO
    stimTable[7] = '{1, 32'h40000000, 8, SeqIncr, 4'hF, 32'h0, 10, 8, 1};
    stimTable[8] = '{1, 32'h50000004, 6, SeqStrm, 4'h5, 32'h0, 20, 6, 1};
    stimTable[9] = '{0, 32'h60000000, 2, SeqIncr, 4'h6, 32'h33330000, 100, 0, 1};
    totalBeats = 0;
    for (int t = 0; t < NumTests; t++)
      totalBeats += stimTable[t].len;
    timeoutLimit = totalBeats * 40 + 200;
    rdIssued = 0;
    cycleCount = 0;
    readRequest = 1'b0;
    writeRequest = 1'b0;
    streamReady = 1'b0;
    curRead = 1'b0;
    sawStall = 1'b0;
    address = '0;
    burstLength = 1;
    burstSeq = SeqIncr;
    byteEnables = '0;
    writeData = '0;
    curBase = '0;
    curLen = '0;
    curSeq = SeqIncr;
    curBe = '0;
    curWd = '0;
    curDuty = '0;
    reqBeat = 0;
    wrBeat = 0;
    streamBeats = 0;
    reset = 1'b1;
    repeat (8) @(negedge Clk);
    reset = 1'b0;
    stepCycle();
    checkFlag(MCmd == CmdIdle, 1'b1, "MCmd idle after reset");
    checkFlag(busy, 1'b0, "busy after reset");
    checkFlag(streamValid, 1'b0, "streamValid after reset");
    checkFlag(respError, 1'b0, "respError after reset");
    checkFlag(MRespAccept, 1'b1, "MRespAccept after reset");
    for (int t = 0; t < NumTests; t++) begin
      s = stimTable[t];
      while (busy)
        stepCycle();
      curRead = s.isRead;
      curBase = s.addr;
      curLen = s.len;
      curSeq = s.seq;
      curBe = s.be;
      curWd = s.wdBase;
      curDuty = s.duty;
      reqBeat = 0;
      wrBeat = 0;
      streamBeats = 0;
      if (s.isRead) begin
        queueExpected(s.addr, s.len, s.seq);
        rdIssued += s.len;
      end
      readRequest  = s.isRead;
      writeRequest = !s.isRead;
      address      = s.addr;
      burstLength  = s.len;
      burstSeq     = s.seq;
      byteEnables  = s.be;
      writeData    = s.wdBase;
      stepCycle();
      readRequest  = 1'b0;
      writeRequest = 1'b0;
      while (reqBeat < curLen)
        stepCycle();
      // Every read response taken and every due beat streamed
      while (respDone != rdIssued || expData.size() != 0)
        stepCycle();
      stepCycle();
      checkFlag(streamBeats == s.expBeats, 1'b1, "stream beat count of the burst");
      checkFlag(respError, s.expErr, "respError");
    end
    repeat (5) stepCycle();
    checkFlag(streamValid, 1'b0, "streamValid after the last burst");
    checkFlag(sawStall, 1'b1, "MRespAccept drop under back-pressure");
    checkFlag(acceptedBeats == totalBeats, 1'b1, "slave count of accepted beats");
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* tb/ocpSlaveModel.sv */
/*
  Behavioral OCP slave for the master testbench.
  SCmdAccept is random per cycle. Each accepted RD beat queues one response.
  Address bits 31:28 of E give ERR, of F give FAIL, anything else gives DVA.
  Response data is the beat address XOR 32'h5A5A0000, returned in order.
  A response holds until MRespAccept is sampled high.
*/
`timescale 1ns/1ps

module ocpSlaveModel (
  input  logic             Clk,
  input  logic             reset,
  // OCP request group
  input  ocpPkg::ocpCmdT   MCmd,
  input  ocpPkg::addrT     MAddr,
  input  ocpPkg::burstLenT MBurstLength,
  output logic             SCmdAccept,
  // OCP response group
  output ocpPkg::ocpRespT  SResp,
  output ocpPkg::dataT     SData,
  output logic             SRespLast,
  input  logic             MRespAccept,
  // Beat log for the testbench
  output int               acceptCount,
  output int               respCount
);
  import ocpPkg::*;

  // Pending responses as {code, data, last}
  logic [34:0] respQueue [$];
  logic [34:0] head;
  burstLenT    burstBeat;
  ocpRespT     code;

  initial begin
    SCmdAccept  = 1'b0;
    SResp       = RespNull;
    SData       = '0;
    SRespLast   = 1'b0;
    acceptCount = 0;
    respCount   = 0;
    burstBeat   = '0;
  end

  always @(posedge Clk) begin
    if (reset) begin
      SCmdAccept  <= 1'b0;
      SResp       <= RespNull;
      SRespLast   <= 1'b0;
      acceptCount <= 0;
      respCount   <= 0;
      burstBeat   = '0;
      respQueue.delete();
    end else begin
      // Request beat taken on this edge
      if ((MCmd != CmdIdle) && SCmdAccept) begin
        acceptCount <= acceptCount + 1;
        if (MCmd == CmdRd) begin
          case (MAddr[31:28])
            4'hE:    code = RespErr;
            4'hF:    code = RespFail;
            default: code = RespDva;
          endcase
          respQueue.push_back({code, MAddr ^ 32'h5A5A0000,
                               burstBeat == MBurstLength - 1'b1});
        end
        // Own beat count within the burst
        burstBeat = (burstBeat == MBurstLength - 1'b1) ? '0 : burstBeat + 1'b1;
      end
      // Roughly two accepts in three cycles
      SCmdAccept <= (($urandom % 3) != 0);
      // Shown response retires only when the master takes it
      if ((SResp != RespNull) && MRespAccept) begin
        void'(respQueue.pop_front());
        respCount <= respCount + 1;
      end
      if (respQueue.size() != 0) begin
        head = respQueue[0];
        SResp     <= ocpRespT'(head[34:33]);
        SData     <= head[32:1];
        SRespLast <= head[0];
      end else begin
        SResp     <= RespNull;
        SRespLast <= 1'b0;
      end
    end
  end

endmodule

/* src/ocpMaster.sv */
/*
  OCP read/write master with an AXI-Stream read data output.
  Writes are posted and produce no stream traffic.
  Response to streamValid latency is two cycles or more, varies with
  back-pressure. A full response FIFO drops MRespAccept.
*/
`timescale 1ns/1ps

module ocpMaster (
  input  logic             Clk,
  input  logic             reset,
  // Bridge side
  input  logic             readRequest,
  input  logic             writeRequest,
  input  ocpPkg::addrT     address,
  input  ocpPkg::burstLenT burstLength,
  input  ocpPkg::burstSeqT burstSeq,
  input  ocpPkg::byteEnT   byteEnables,
  input  ocpPkg::dataT     writeData,
  output logic             busy,
  output logic             writeDataAccept,
  // OCP request group
  output ocpPkg::ocpCmdT   MCmd,
  output ocpPkg::addrT     MAddr,
  output ocpPkg::dataT     MData,
  output ocpPkg::byteEnT   MByteEn,
  output ocpPkg::burstLenT MBurstLength,
  output ocpPkg::burstSeqT MBurstSeq,
  output logic             MReqLast,
  input  logic             SCmdAccept,
  // OCP response group
  input  ocpPkg::ocpRespT  SResp,
  input  ocpPkg::dataT     SData,
  input  logic             SRespLast,
  output logic             MRespAccept,
  // AXI-Stream output
  output logic             streamValid,
  input  logic             streamReady,
  output ocpPkg::dataT     streamData,
  output ocpPkg::byteEnT   streamKeep,
  output logic             streamLast,
  // Sticky ERR indication
  output logic             respError
);
  import ocpPkg::*;

  // Capture to FIFO
  logic     push;
  respBeatT pushData;
  logic     full;
  // FIFO to stream stage
  logic     pop;
  respBeatT popData;
  logic     empty;

  ocpRequestFsm i_ocpRequestFsm (
    .Clk             (Clk),
    .reset           (reset),
    .readRequest     (readRequest),
    .writeRequest    (writeRequest),
    .address         (address),
    .burstLength     (burstLength),
    .burstSeq        (burstSeq),
    .byteEnables     (byteEnables),
    .writeData       (writeData),
    .busy            (busy),
    .writeDataAccept (writeDataAccept),
    .MCmd            (MCmd),
    .MAddr           (MAddr),
    .MData           (MData),
    .MByteEn         (MByteEn),
    .MBurstLength    (MBurstLength),
    .MBurstSeq       (MBurstSeq),
    .MReqLast        (MReqLast),
    .SCmdAccept      (SCmdAccept)
  );

  ocpRespCapture i_ocpRespCapture (
    .Clk         (Clk),
    .reset       (reset),
    .SResp       (SResp),
    .SData       (SData),
    .SRespLast   (SRespLast),
    .MRespAccept (MRespAccept),
    .full        (full),
    .push        (push),
    .pushData    (pushData),
    .respError   (respError)
  );

  // Response buffer
  respFifo #(
    .PayloadT (respBeatT),
    .Depth    (RespFifoDepth)
  ) i_respFifo (
    .Clk      (Clk),
    .reset    (reset),
    .push     (push),
    .pushData (pushData),
    .full     (full),
    .pop      (pop),
    .popData  (popData),
    .empty    (empty)
  );

  respStreamOut i_respStreamOut (
    .Clk         (Clk),
    .reset       (reset),
    .empty       (empty),
    .popData     (popData),
    .pop         (pop),
    .streamValid (streamValid),
    .streamReady (streamReady),
    .streamData  (streamData),
    .streamKeep  (streamKeep),
    .streamLast  (streamLast)
  );

endmodule

/* src/respStreamOut.sv */
/*
  One-beat AXI-Stream output register fed from the response FIFO.
  Refills from the FIFO when empty or when the held beat transfers.
  tkeep is all ones for a DVA beat and all zeros for a FAIL beat.
*/
`timescale 1ns/1ps

module respStreamOut (
  input  logic             Clk,
  input  logic             reset,
  // FIFO read side
  input  logic             empty,
  input  ocpPkg::respBeatT popData,
  output logic             pop,
  // AXI-Stream master
  output logic             streamValid,
  input  logic             streamReady,
  output ocpPkg::dataT     streamData,
  output ocpPkg::byteEnT   streamKeep,
  output logic             streamLast
);
  import ocpPkg::*;

  // Holding register free now or after this transfer
  assign pop = !empty && (!streamValid || streamReady);

  always_ff @(posedge Clk) begin
    if (reset) begin
      streamValid <= 1'b0;
    end else if (pop) begin
      streamValid <= 1'b1;
    end else if (streamReady) begin
      streamValid <= 1'b0;
    end
  end

  // Beat payload
  always_ff @(posedge Clk) begin
    if (pop) begin
      streamData <= popData.data;
      streamKeep <= popData.fail ? '0 : '1;
      streamLast <= popData.last;
    end
  end

  // FIFO head waits unchanged while the output stalls
  assert property (@(posedge Clk) disable iff (reset)
    (!empty && !pop) |=> $stable(popData))
    else $error("FIFO head changed before it was popped");

endmodule

/* src/ocpRespCapture.sv */
/*
  Captures OCP read responses into the response FIFO.
  DVA and FAIL responses are queued with FAIL flagged in the payload.
  ERR responses are accepted and dropped and set a sticky error flag.
  MRespAccept follows the FIFO full flag, so the slave must hold its
  response while MRespAccept is low.
*/
`timescale 1ns/1ps

module ocpRespCapture (
  input  logic             Clk,
  input  logic             reset,
  // OCP response group
  input  ocpPkg::ocpRespT  SResp,
  input  ocpPkg::dataT     SData,
  input  logic             SRespLast,
  output logic             MRespAccept,
  // FIFO write side
  input  logic             full,
  output logic             push,
  output ocpPkg::respBeatT pushData,
  output logic             respError
);
  import ocpPkg::*;

  logic respTaken;

  // Room in the buffer means the response is taken
  assign MRespAccept = !full;
  assign respTaken   = (SResp != RespNull) && MRespAccept;

  // Only data-carrying responses go to the stream
  assign push = respTaken && ((SResp == RespDva) || (SResp == RespFail));

  assign pushData.data = SData;
  assign pushData.fail = (SResp == RespFail);
  assign pushData.last = SRespLast;

  // Sticky until reset
  always_ff @(posedge Clk) begin
    if (reset) begin
      respError <= 1'b0;
    end else if (respTaken && (SResp == RespErr)) begin
      respError <= 1'b1;
    end
  end

  // Slave holds a response that the master has not taken
  assert property (@(posedge Clk) disable iff (reset)
    ((SResp != RespNull) && !MRespAccept) |=> ($stable(SResp) && $stable(SData)
      && $stable(SRespLast)))
    else $error("OCP response changed before MRespAccept");

endmodule

/* src/ocpRequestFsm.sv */
/*
  OCP request sequencer for single-beat and burst WR/RD commands.
  Requests are sampled only while busy is low. Read wins over write.
  MData follows writeData combinationally during a write burst, so the
  bridge must hold writeData until writeDataAccept and then show the next beat.
  Any burst sequence other than INCR keeps MAddr fixed, as for STRM.
*/
`timescale 1ns/1ps

module ocpRequestFsm (
  input  logic             Clk,
  input  logic             reset,
  // Bridge side
  input  logic             readRequest,
  input  logic             writeRequest,
  input  ocpPkg::addrT     address,
  input  ocpPkg::burstLenT burstLength,
  input  ocpPkg::burstSeqT burstSeq,
  input  ocpPkg::byteEnT   byteEnables,
  input  ocpPkg::dataT     writeData,
  output logic             busy,
  output logic             writeDataAccept,
  // OCP request group
  output ocpPkg::ocpCmdT   MCmd,
  output ocpPkg::addrT     MAddr,
  output ocpPkg::dataT     MData,
  output ocpPkg::byteEnT   MByteEn,
  output ocpPkg::burstLenT MBurstLength,
  output ocpPkg::burstSeqT MBurstSeq,
  output logic             MReqLast,
  input  logic             SCmdAccept
);
  import ocpPkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StWrite,
    StRead
  } stateT;

  stateT    state;
  // Beats already accepted in this burst
  burstLenT beatCount;
  logic     startRead;
  logic     startWrite;
  logic     beatAccept;
  logic     lastBeat;

  // Read has priority when both strobes are up
  assign startRead  = (state == StIdle) && readRequest;
  assign startWrite = (state == StIdle) && writeRequest && !readRequest;

  // Beat ends on the edge that samples SCmdAccept
  assign beatAccept = (state != StIdle) && SCmdAccept;
  assign lastBeat   = (beatCount == MBurstLength - 1'b1);

  always_ff @(posedge Clk) begin
    if (reset) begin
      state     <= StIdle;
      beatCount <= '0;
    end else begin
      case (state)
        StIdle: begin
          beatCount <= '0;
          if (startRead) begin
            state <= StRead;
          end else if (startWrite) begin
            state <= StWrite;
          end
        end
        StWrite, StRead: begin
          if (beatAccept) begin
            if (lastBeat) begin
              // Back to idle, new request may be sampled next cycle
              state     <= StIdle;
              beatCount <= '0;
            end else begin
              beatCount <= beatCount + 1'b1;
            end
          end
        end
        default: begin
          state <= StIdle;
        end
      endcase
    end
  end

  // Burst attributes latched at start
  always_ff @(posedge Clk) begin
    if (startRead || startWrite) begin
      MAddr        <= address;
      MByteEn      <= byteEnables;
      MBurstLength <= burstLength;
      MBurstSeq    <= burstSeq;
    end else if (beatAccept && !lastBeat && (MBurstSeq == SeqIncr)) begin
      // INCR steps one beat worth of bytes
      MAddr <= MAddr + AddrWidth'(ByteEnWidth);
    end
  end

  always_comb begin
    case (state)
      StWrite: MCmd = CmdWr;
      StRead:  MCmd = CmdRd;
      default: MCmd = CmdIdle;
    endcase
  end

  // Write data rides with the command
  assign MData           = (state == StWrite) ? writeData : '0;
  assign MReqLast        = (state != StIdle) && lastBeat;
  assign busy            = (state != StIdle);
  assign writeDataAccept = (state == StWrite) && SCmdAccept;

  // Request fields, write data from the bridge included, hold until accepted
  assert property (@(posedge Clk) disable iff (reset)
    (busy && !SCmdAccept) |=> ($stable(MCmd) && $stable(MAddr) && $stable(MData)
      && $stable(MByteEn) && $stable(MReqLast)))
    else $error("OCP request fields changed before SCmdAccept");

  // Zero-length bursts never reach the sequencer
  assert property (@(posedge Clk) disable iff (reset)
    (!busy && (readRequest || writeRequest)) |-> (burstLength != '0))
    else $error("Burst request with zero length");

endmodule

/* src/respFifo.sv */
/*
  Synchronous FIFO with a type-parameter payload.
  popData shows the head entry with no read latency whenever empty is low.
  Push while full is taken only together with a pop in the same cycle.
  Depth must be at least 2.
*/
`timescale 1ns/1ps

module respFifo #(
  parameter type PayloadT = logic,
  parameter int  Depth    = 4
) (
  input  logic    Clk,
  input  logic    reset,
  // Write side
  input  logic    push,
  input  PayloadT pushData,
  output logic    full,
  // Read side
  input  logic    pop,
  output PayloadT popData,
  output logic    empty
);

  PayloadT                     mem [Depth];
  logic [$clog2(Depth)-1:0]    wrPtr;
  logic [$clog2(Depth)-1:0]    rdPtr;
  // Entries currently held
  logic [$clog2(Depth+1)-1:0]  count;
  logic                        doPush;
  logic                        doPop;

  assign full  = (count == ($bits(count))'(Depth));
  assign empty = (count == '0);

  // Full FIFO still takes a push when the head leaves this cycle
  assign doPop  = pop && !empty;
  assign doPush = push && (!full || doPop);

  assign popData = mem[rdPtr];

  // Entry storage
  always_ff @(posedge Clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge Clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        // Wrap for non power of two depths
        wrPtr <= (wrPtr == ($bits(wrPtr))'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == ($bits(rdPtr))'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assert property (@(posedge Clk) disable iff (reset)
    pop |-> !empty)
    else $error("Pop from an empty FIFO");

  assert property (@(posedge Clk) disable iff (reset)
    (push && full) |-> pop)
    else $error("Push into a full FIFO without a pop");

endmodule

/* src/ocpPkg.sv */
/*
  Shared widths, OCP encodings and the response payload for the OCP master.
  Address is 32 bits and data is 32 bits, so one beat carries four byte lanes.
  Only IDLE, WR and RD are issued, and only INCR and STRM bursts are sequenced.
  Burst length must be nonzero. The counter width limits a burst to 1023 beats.
*/
package ocpPkg;

  // Basic group widths
  localparam int AddrWidth     = 32;
  localparam int DataWidth     = 32;
  localparam int ByteEnWidth   = DataWidth / 8;
  localparam int BurstWidth    = 10;
  // Default response buffer depth
  localparam int RespFifoDepth = 4;

  typedef logic [AddrWidth-1:0]   addrT;
  typedef logic [DataWidth-1:0]   dataT;
  typedef logic [ByteEnWidth-1:0] byteEnT;
  typedef logic [BurstWidth-1:0]  burstLenT;

  // MCmd codes
  typedef enum logic [2:0] {
    CmdIdle = 3'b000,
    CmdWr   = 3'b001,
    CmdRd   = 3'b010,
    CmdRdex = 3'b011,
    CmdRdl  = 3'b100,
    CmdWrnp = 3'b101,
    CmdWrc  = 3'b110,
    CmdBcst = 3'b111
  } ocpCmdT;

  // SResp codes
  typedef enum logic [1:0] {
    RespNull = 2'b00,
    RespDva  = 2'b01,
    RespFail = 2'b10,
    RespErr  = 2'b11
  } ocpRespT;

  // MBurstSeq codes
  typedef enum logic [2:0] {
    SeqIncr  = 3'b000,
    SeqDflt1 = 3'b001,
    SeqWrap  = 3'b010,
    SeqDflt2 = 3'b011,
    SeqXor   = 3'b100,
    SeqStrm  = 3'b101,
    SeqUnkn  = 3'b110,
    SeqBlck  = 3'b111
  } burstSeqT;

  // One captured read response, as queued for the stream
  typedef struct packed {
    dataT data;
    logic fail;
    logic last;
  } respBeatT;

endpackage
